//--- fads_pkg.sv
`default_nettype none

package fads_pkg;

    // datapath widths
    localparam int ADC_W   = 14;
    localparam int CNT_W   = 32;
    localparam int CLASS_W = 8;

    typedef logic signed [ADC_W-1:0] adc_sample_t;
    typedef logic [CNT_W-1:0]        cnt_t;
    typedef logic [CLASS_W-1:0]      class_t;

    // bit positions in the classification byte, bit 6 unused
    localparam int CLASS_LOW_INT   = 0;
    localparam int CLASS_POS_INT   = 1;
    localparam int CLASS_HIGH_INT  = 2;
    localparam int CLASS_SHORT     = 3;
    localparam int CLASS_POS_WIDTH = 4;
    localparam int CLASS_LONG      = 5;
    localparam int CLASS_POSITIVE  = 7;

    // 125 MHz adc clock gives one tick per microsecond
    localparam int CYCLES_PER_US = 125;
    localparam int PRESC_W       = $clog2(CYCLES_PER_US);

    // register map, low address bits only
    localparam int BUS_ADDR_W = 20;
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    localparam bus_addr_t REG_MIN_INT       = 20'h00000;
    localparam bus_addr_t REG_LOW_INT       = 20'h00004;
    localparam bus_addr_t REG_HIGH_INT      = 20'h00008;
    localparam bus_addr_t REG_MIN_WIDTH     = 20'h00010;
    localparam bus_addr_t REG_LOW_WIDTH     = 20'h00014;
    localparam bus_addr_t REG_HIGH_WIDTH    = 20'h00018;
    localparam bus_addr_t REG_SORT_CTRL     = 20'h00020;
    localparam bus_addr_t REG_SORT_DELAY    = 20'h00024;
    localparam bus_addr_t REG_SORT_DURATION = 20'h00028;
    localparam bus_addr_t REG_CNT_LOW_INT   = 20'h00100;
    localparam bus_addr_t REG_CNT_HIGH_INT  = 20'h00104;
    localparam bus_addr_t REG_CNT_SHORT     = 20'h00108;
    localparam bus_addr_t REG_CNT_LONG      = 20'h0010C;
    localparam bus_addr_t REG_CNT_POSITIVE  = 20'h00110;
    localparam bus_addr_t REG_CNT_NEGATIVE  = 20'h00114;
    localparam bus_addr_t REG_DROPLET_ID    = 20'h00200;
    localparam bus_addr_t REG_LAST_INT      = 20'h00204;
    localparam bus_addr_t REG_LAST_WIDTH    = 20'h00208;
    localparam bus_addr_t REG_LAST_CLASS    = 20'h0020C;
    localparam bus_addr_t REG_LAST_TIME     = 20'h00210;

    // reset values of the writable registers
    localparam adc_sample_t DEF_MIN_INT       = -14'sd250;
    localparam adc_sample_t DEF_LOW_INT       = -14'sd240;
    localparam adc_sample_t DEF_HIGH_INT      = 14'sd500;
    localparam cnt_t        DEF_MIN_WIDTH     = 32'd1;
    localparam cnt_t        DEF_LOW_WIDTH     = 32'd4;
    localparam cnt_t        DEF_HIGH_WIDTH    = 32'd64;
    localparam cnt_t        DEF_SORT_DELAY    = 32'd31250;
    localparam cnt_t        DEF_SORT_DURATION = 32'd125000;
    localparam logic        DEF_SORT_EN       = 1'b1;

endpackage

`default_nettype wire

//--- fads_us_timer.sv
`timescale 1ns/1ns
`default_nettype none

module fads_us_timer import fads_pkg::*; (
    input  wire  adc_clk_i,
    input  wire  fads_reset,
    output cnt_t time_us_o
);

    // cycles within the current microsecond
    logic [PRESC_W-1:0] presc;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            presc     <= '0;
            time_us_o <= '0;
        end else if (presc == PRESC_W'(CYCLES_PER_US - 1)) begin
            presc     <= '0;
            // wraps freely, no saturation
            time_us_o <= time_us_o + cnt_t'(1);
        end else begin
            presc <= presc + PRESC_W'(1);
        end
    end

endmodule

`default_nettype wire

//--- fads_droplet_detector.sv
`timescale 1ns/1ns
`default_nettype none

module fads_droplet_detector import fads_pkg::*; (
    input  wire         adc_clk_i,
    input  wire         fads_reset,
    input  adc_sample_t adc_i,
    input  wire         signal_stable_i,
    input  adc_sample_t min_int_i,
    input  wire         sort_busy_i,
    output logic        droplet_done_o,
    output adc_sample_t peak_o,
    output cnt_t        width_o
);

    typedef enum logic {
        S_WAIT,
        S_ACQ
    } state_t;

    state_t state;
    logic   above;

    // signed compare against the droplet threshold
    assign above = adc_i >= min_int_i;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state          <= S_WAIT;
            droplet_done_o <= 1'b0;
            peak_o         <= '0;
            width_o        <= '0;
        end else begin
            droplet_done_o <= 1'b0;
            case (state)
                S_WAIT: begin
                    // no new droplet while a sort runs
                    if (signal_stable_i && above && !sort_busy_i) begin
                        state   <= S_ACQ;
                        peak_o  <= adc_i;
                        width_o <= cnt_t'(1);
                    end
                end
                S_ACQ: begin
                    // unstable samples neither extend nor end the droplet
                    if (signal_stable_i) begin
                        if (above) begin
                            width_o <= width_o + cnt_t'(1);
                            if (adc_i > peak_o) begin
                                peak_o <= adc_i;
                            end
                        end else begin
                            // peak and width stay put through the done pulse
                            state          <= S_WAIT;
                            droplet_done_o <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= S_WAIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fads_droplet_eval.sv
`timescale 1ns/1ns
`default_nettype none

module fads_droplet_eval import fads_pkg::*; (
    input  wire         adc_clk_i,
    input  wire         fads_reset,
    input  wire         droplet_done_i,
    input  adc_sample_t peak_i,
    input  cnt_t        width_i,
    input  adc_sample_t min_int_i,
    input  adc_sample_t low_int_i,
    input  adc_sample_t high_int_i,
    input  cnt_t        min_width_i,
    input  cnt_t        low_width_i,
    input  cnt_t        high_width_i,
    input  wire         sort_en_i,
    input  cnt_t        time_us_i,
    output logic        sort_start_o,
    output cnt_t        cnt_low_int_o,
    output cnt_t        cnt_high_int_o,
    output cnt_t        cnt_short_o,
    output cnt_t        cnt_long_o,
    output cnt_t        cnt_positive_o,
    output cnt_t        cnt_negative_o,
    output cnt_t        droplet_id_o,
    output adc_sample_t last_int_o,
    output cnt_t        last_width_o,
    output class_t      last_class_o,
    output cnt_t        last_time_o
);

    logic   accept;
    logic   int_low, int_pos, int_high;
    logic   wid_short, wid_pos, wid_long;
    logic   positive;
    class_t cls;

    // droplets narrower than min_width are dropped
    // min_int already gates the detector
    assign accept = width_i >= min_width_i;

    // intensity class by signed compares
    assign int_low  = peak_i < low_int_i;
    assign int_pos  = (peak_i >= low_int_i) && (peak_i < high_int_i);
    assign int_high = peak_i >= high_int_i;

    // width class
    assign wid_short = width_i < low_width_i;
    assign wid_pos   = (width_i >= low_width_i) && (width_i < high_width_i);
    assign wid_long  = width_i >= high_width_i;

    assign positive = int_pos && wid_pos;

    always_comb begin
        cls                  = '0;
        cls[CLASS_LOW_INT]   = int_low;
        cls[CLASS_POS_INT]   = int_pos;
        cls[CLASS_HIGH_INT]  = int_high;
        cls[CLASS_SHORT]     = wid_short;
        cls[CLASS_POS_WIDTH] = wid_pos;
        cls[CLASS_LONG]      = wid_long;
        cls[CLASS_POSITIVE]  = positive;
    end

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            sort_start_o   <= 1'b0;
            cnt_low_int_o  <= '0;
            cnt_high_int_o <= '0;
            cnt_short_o    <= '0;
            cnt_long_o     <= '0;
            cnt_positive_o <= '0;
            cnt_negative_o <= '0;
            droplet_id_o   <= '0;
            last_int_o     <= '0;
            last_width_o   <= '0;
            last_class_o   <= '0;
            last_time_o    <= '0;
        end else begin
            sort_start_o <= 1'b0;
            if (droplet_done_i && accept) begin
                droplet_id_o <= droplet_id_o + cnt_t'(1);
                // record of the last accepted droplet
                last_int_o   <= peak_i;
                last_width_o <= width_i;
                last_class_o <= cls;
                last_time_o  <= time_us_i;
                cnt_low_int_o  <= cnt_low_int_o + cnt_t'(int_low);
                cnt_high_int_o <= cnt_high_int_o + cnt_t'(int_high);
                cnt_short_o    <= cnt_short_o + cnt_t'(wid_short);
                cnt_long_o     <= cnt_long_o + cnt_t'(wid_long);
                cnt_positive_o <= cnt_positive_o + cnt_t'(positive);
                cnt_negative_o <= cnt_negative_o + cnt_t'(!positive);
                // one cycle after done
                sort_start_o <= positive && sort_en_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- fads_sort_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module fads_sort_sequencer import fads_pkg::*; (
    input  wire  adc_clk_i,
    input  wire  fads_reset,
    input  wire  sort_start_i,
    input  cnt_t sort_delay_i,
    input  cnt_t sort_duration_i,
    output logic sort_busy_o,
    output logic sort_trig_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DELAY,
        S_TRIG
    } state_t;

    state_t state;
    // cycles spent in the current phase
    cnt_t   cnt;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    // zero delay goes straight to the trigger
                    if (sort_start_i) begin
                        if (sort_delay_i != '0) begin
                            state <= S_DELAY;
                        end else if (sort_duration_i != '0) begin
                            state <= S_TRIG;
                        end
                    end
                end
                S_DELAY: begin
                    if (cnt == sort_delay_i - cnt_t'(1)) begin
                        cnt   <= '0;
                        state <= (sort_duration_i != '0) ? S_TRIG : S_IDLE;
                    end else begin
                        cnt <= cnt + cnt_t'(1);
                    end
                end
                S_TRIG: begin
                    if (cnt == sort_duration_i - cnt_t'(1)) begin
                        cnt   <= '0;
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt + cnt_t'(1);
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // trigger high for exactly the trigger phase
    assign sort_trig_o = state == S_TRIG;
    assign sort_busy_o = state != S_IDLE;

endmodule

`default_nettype wire

//--- fads_regs.sv
`timescale 1ns/1ns
`default_nettype none

module fads_regs import fads_pkg::*; (
    input  wire         adc_clk_i,
    input  wire         fads_reset,
    input  wire  [31:0] sys_addr_i,
    input  wire  [31:0] sys_wdata_i,
    input  wire         sys_wen_i,
    input  wire         sys_ren_i,
    input  cnt_t        cnt_low_int_i,
    input  cnt_t        cnt_high_int_i,
    input  cnt_t        cnt_short_i,
    input  cnt_t        cnt_long_i,
    input  cnt_t        cnt_positive_i,
    input  cnt_t        cnt_negative_i,
    input  cnt_t        droplet_id_i,
    input  adc_sample_t last_int_i,
    input  cnt_t        last_width_i,
    input  class_t      last_class_i,
    input  cnt_t        last_time_i,
    output logic [31:0] sys_rdata_o,
    output logic        sys_ack_o,
    output adc_sample_t min_int_o,
    output adc_sample_t low_int_o,
    output adc_sample_t high_int_o,
    output cnt_t        min_width_o,
    output cnt_t        low_width_o,
    output cnt_t        high_width_o,
    output logic        sort_en_o,
    output cnt_t        sort_delay_o,
    output cnt_t        sort_duration_o
);

    bus_addr_t   addr;
    logic [31:0] rdata;

    // intensity values read back sign-extended
    function automatic logic [31:0] sext(input adc_sample_t v);
        return {{(32 - ADC_W){v[ADC_W-1]}}, v};
    endfunction

    // only the low address bits are decoded
    assign addr = sys_addr_i[BUS_ADDR_W-1:0];

    // write decode, read-only offsets fall through
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            min_int_o       <= DEF_MIN_INT;
            low_int_o       <= DEF_LOW_INT;
            high_int_o      <= DEF_HIGH_INT;
            min_width_o     <= DEF_MIN_WIDTH;
            low_width_o     <= DEF_LOW_WIDTH;
            high_width_o    <= DEF_HIGH_WIDTH;
            sort_en_o       <= DEF_SORT_EN;
            sort_delay_o    <= DEF_SORT_DELAY;
            sort_duration_o <= DEF_SORT_DURATION;
        end else if (sys_wen_i) begin
            case (addr)
                REG_MIN_INT:       min_int_o       <= sys_wdata_i[ADC_W-1:0];
                REG_LOW_INT:       low_int_o       <= sys_wdata_i[ADC_W-1:0];
                REG_HIGH_INT:      high_int_o      <= sys_wdata_i[ADC_W-1:0];
                REG_MIN_WIDTH:     min_width_o     <= sys_wdata_i;
                REG_LOW_WIDTH:     low_width_o     <= sys_wdata_i;
                REG_HIGH_WIDTH:    high_width_o    <= sys_wdata_i;
                REG_SORT_CTRL:     sort_en_o       <= sys_wdata_i[0];
                REG_SORT_DELAY:    sort_delay_o    <= sys_wdata_i;
                REG_SORT_DURATION: sort_duration_o <= sys_wdata_i;
                default: ;
            endcase
        end
    end

    // read mux, unmapped offsets give zero
    always_comb begin
        case (addr)
            REG_MIN_INT:       rdata = sext(min_int_o);
            REG_LOW_INT:       rdata = sext(low_int_o);
            REG_HIGH_INT:      rdata = sext(high_int_o);
            REG_MIN_WIDTH:     rdata = min_width_o;
            REG_LOW_WIDTH:     rdata = low_width_o;
            REG_HIGH_WIDTH:    rdata = high_width_o;
            REG_SORT_CTRL:     rdata = {31'd0, sort_en_o};
            REG_SORT_DELAY:    rdata = sort_delay_o;
            REG_SORT_DURATION: rdata = sort_duration_o;
            REG_CNT_LOW_INT:   rdata = cnt_low_int_i;
            REG_CNT_HIGH_INT:  rdata = cnt_high_int_i;
            REG_CNT_SHORT:     rdata = cnt_short_i;
            REG_CNT_LONG:      rdata = cnt_long_i;
            REG_CNT_POSITIVE:  rdata = cnt_positive_i;
            REG_CNT_NEGATIVE:  rdata = cnt_negative_i;
            REG_DROPLET_ID:    rdata = droplet_id_i;
            REG_LAST_INT:      rdata = sext(last_int_i);
            REG_LAST_WIDTH:    rdata = last_width_i;
            REG_LAST_CLASS:    rdata = {{(32 - CLASS_W){1'b0}}, last_class_i};
            REG_LAST_TIME:     rdata = last_time_i;
            default:           rdata = '0;
        endcase
    end

    // ack one cycle after any access, data valid with it
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            sys_ack_o   <= 1'b0;
            sys_rdata_o <= '0;
        end else begin
            sys_ack_o <= sys_wen_i || sys_ren_i;
            if (sys_ren_i) begin
                sys_rdata_o <= rdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- fads_top.sv
`timescale 1ns/1ns
`default_nettype none

module fads_top import fads_pkg::*; (
    input  wire         adc_clk_i,
    input  wire         fads_reset,
    input  adc_sample_t adc_a_i,
    input  wire         signal_stable_i,
    input  wire  [31:0] sys_addr_i,
    input  wire  [31:0] sys_wdata_i,
    input  wire         sys_wen_i,
    input  wire         sys_ren_i,
    output logic        sort_trig_o,
    output logic [31:0] sys_rdata_o,
    output logic        sys_ack_o
);

    // settings from the register bank
    adc_sample_t min_int, low_int, high_int;
    cnt_t        min_width, low_width, high_width;
    logic        sort_en;
    cnt_t        sort_delay, sort_duration;

    // detector to eval
    logic        droplet_done;
    adc_sample_t peak;
    cnt_t        width;

    // statistics and last record
    cnt_t        cnt_low_int, cnt_high_int, cnt_short, cnt_long;
    cnt_t        cnt_positive, cnt_negative, droplet_id;
    adc_sample_t last_int;
    cnt_t        last_width, last_time;
    class_t      last_class;

    cnt_t        time_us;
    logic        sort_start, sort_busy;

    fads_us_timer timer_i (
        .adc_clk_i, .fads_reset, .time_us_o(time_us)
    );

    fads_droplet_detector det_i (
        .adc_clk_i, .fads_reset, .adc_i(adc_a_i), .signal_stable_i,
        .min_int_i(min_int), .sort_busy_i(sort_busy),
        .droplet_done_o(droplet_done), .peak_o(peak), .width_o(width)
    );

    fads_droplet_eval eval_i (
        .adc_clk_i, .fads_reset, .droplet_done_i(droplet_done), .peak_i(peak),
        .width_i(width), .min_int_i(min_int), .low_int_i(low_int),
        .high_int_i(high_int), .min_width_i(min_width), .low_width_i(low_width),
        .high_width_i(high_width), .sort_en_i(sort_en), .time_us_i(time_us),
        .sort_start_o(sort_start), .cnt_low_int_o(cnt_low_int),
        .cnt_high_int_o(cnt_high_int), .cnt_short_o(cnt_short),
        .cnt_long_o(cnt_long), .cnt_positive_o(cnt_positive),
        .cnt_negative_o(cnt_negative), .droplet_id_o(droplet_id),
        .last_int_o(last_int), .last_width_o(last_width),
        .last_class_o(last_class), .last_time_o(last_time)
    );

    fads_sort_sequencer seq_i (
        .adc_clk_i, .fads_reset, .sort_start_i(sort_start),
        .sort_delay_i(sort_delay), .sort_duration_i(sort_duration),
        .sort_busy_o(sort_busy), .sort_trig_o
    );

    fads_regs regs_i (
        .adc_clk_i, .fads_reset, .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
        .cnt_low_int_i(cnt_low_int), .cnt_high_int_i(cnt_high_int),
        .cnt_short_i(cnt_short), .cnt_long_i(cnt_long),
        .cnt_positive_i(cnt_positive), .cnt_negative_i(cnt_negative),
        .droplet_id_i(droplet_id), .last_int_i(last_int),
        .last_width_i(last_width), .last_class_i(last_class),
        .last_time_i(last_time), .sys_rdata_o, .sys_ack_o,
        .min_int_o(min_int), .low_int_o(low_int), .high_int_o(high_int),
        .min_width_o(min_width), .low_width_o(low_width),
        .high_width_o(high_width), .sort_en_o(sort_en),
        .sort_delay_o(sort_delay), .sort_duration_o(sort_duration)
    );

endmodule

`default_nettype wire

//--- tb_fads_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fads_checker (
    input  wire         adc_clk_i,
    input  wire         fads_reset,
    input  wire         ack_i,
    input  wire  [31:0] rdata_i,
    input  wire         trig_i,
    input  wire         rd_armed_i,
    input  wire  [31:0] exp_addr_i,
    input  wire  [31:0] exp_data_i,
    input  wire         trig_armed_i,
    input  wire  [31:0] trig_len_i,
    output logic [31:0] errors_o,
    output logic [31:0] pulses_o
);

    // high cycles of the trigger pulse in progress
    logic [31:0] trig_run;

    // sampled on the falling edge, away from the dut updates
    always @(negedge adc_clk_i) begin
        logic [31:0] add;
        add = 32'd0;
        if (fads_reset) begin
            errors_o <= 32'd0;
            pulses_o <= 32'd0;
            trig_run <= 32'd0;
        end else begin
            // read data is valid with the ack
            if (ack_i && rd_armed_i && (rdata_i !== exp_data_i)) begin
                $display("ERROR at %0t ns: read of offset 0x%h returned 0x%h, expected 0x%h",
                         $time, exp_addr_i, rdata_i, exp_data_i);
                add = add + 32'd1;
            end
            if (trig_i) begin
                trig_run <= trig_run + 32'd1;
            end else if (trig_run != 32'd0) begin
                // pulse just ended
                pulses_o <= pulses_o + 32'd1;
                trig_run <= 32'd0;
                if (!trig_armed_i) begin
                    $display("ERROR at %0t ns: sort trigger of %0d cycles, none expected",
                             $time, trig_run);
                    add = add + 32'd1;
                end else if (trig_run != trig_len_i) begin
                    $display("ERROR at %0t ns: sort trigger high for %0d cycles, expected %0d",
                             $time, trig_run, trig_len_i);
                    add = add + 32'd1;
                end
            end
            errors_o <= errors_o + add;
        end
    end

endmodule

`default_nettype wire

//--- tb_fads.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fads import fads_pkg::*; ();

    localparam int ACK_TIMEOUT  = 20;
    localparam int TRIG_TIMEOUT = 2000;
    localparam int IDLE_SAMPLE  = -1000;

    logic        adc_clk;
    logic        fads_reset;
    adc_sample_t adc_a;
    logic        signal_stable;
    logic [31:0] sys_addr;
    logic [31:0] sys_wdata;
    logic [31:0] sys_rdata;
    logic        sys_wen;
    logic        sys_ren;
    logic        sys_ack;
    logic        sort_trig;

    // expectations handed to the checker
    logic        rd_armed;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic        trig_armed;
    logic [31:0] trig_len;
    logic [31:0] chk_errors;
    logic [31:0] pulses;

    int local_errors;
    bit timed_out;

    fads_top dut_i (
        .adc_clk_i(adc_clk), .fads_reset(fads_reset), .adc_a_i(adc_a),
        .signal_stable_i(signal_stable), .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata),
        .sys_wen_i(sys_wen), .sys_ren_i(sys_ren), .sort_trig_o(sort_trig),
        .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack)
    );

    tb_fads_checker chk_i (
        .adc_clk_i(adc_clk), .fads_reset(fads_reset), .ack_i(sys_ack), .rdata_i(sys_rdata),
        .trig_i(sort_trig), .rd_armed_i(rd_armed), .exp_addr_i(exp_addr),
        .exp_data_i(exp_data), .trig_armed_i(trig_armed), .trig_len_i(trig_len),
        .errors_o(chk_errors), .pulses_o(pulses)
    );

    initial begin
        adc_clk = 1'b0;
        forever #5 adc_clk = ~adc_clk;
    end

    // inputs move 1 ns after the rising edge
    task automatic step();
        @(posedge adc_clk);
        #1;
    endtask

    task automatic wait_ack(input logic [31:0] a);
        bit got;
        got = 1'b0;
        for (int n = 0; n < ACK_TIMEOUT && !got; n++) begin
            @(negedge adc_clk);
            if (sys_ack) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            $display("timeout: no bus ack for the access to offset 0x%h", a);
            local_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        step();
        sys_addr  = a;
        sys_wdata = d;
        sys_wen   = 1'b1;
        step();
        sys_wen = 1'b0;
        wait_ack(a);
    endtask

    task automatic bus_read(input logic [31:0] a, input logic [31:0] d);
        step();
        exp_addr = a;
        exp_data = d;
        rd_armed = 1'b1;
        sys_addr = a;
        sys_ren  = 1'b1;
        step();
        sys_ren = 1'b0;
        wait_ack(a);
        step();
        rd_armed = 1'b0;
    endtask

    // unstable cycles with a sample that would otherwise end a droplet
    task automatic idle_gap();
        int g;
        g = 2 + int'($urandom % 7);
        for (int i = 0; i < g; i++) begin
            step();
            adc_a         = adc_sample_t'(IDLE_SAMPLE);
            signal_stable = 1'b0;
        end
    endtask

    task automatic run_samples(input int sval, input int cnt);
        for (int i = 0; i < cnt; i++) begin
            step();
            adc_a         = adc_sample_t'(sval);
            signal_stable = 1'b1;
        end
        idle_gap();
    endtask

    task automatic wait_trigger(input int len);
        logic [31:0] start;
        bit          got;
        step();
        trig_len   = len;
        trig_armed = 1'b1;
        start      = pulses;
        got        = 1'b0;
        for (int n = 0; n < TRIG_TIMEOUT && !got; n++) begin
            @(negedge adc_clk);
            if (pulses != start) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            $display("timeout: the sort trigger pulse did not complete");
            local_errors++;
            timed_out = 1'b1;
        end
        step();
        trig_armed = 1'b0;
    endtask

    initial begin
        int          fd;
        int          code;
        int          seed;
        int          sval;
        int          cnt;
        int          tests_run;
        int          tests_failed;
        int          errs_before;
        int          total;
        byte         op;
        string       line;
        string       rest;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        adc_a         = adc_sample_t'(IDLE_SAMPLE);
        signal_stable = 1'b0;
        sys_addr      = '0;
        sys_wdata     = '0;
        sys_wen       = 1'b0;
        sys_ren       = 1'b0;
        rd_armed      = 1'b0;
        exp_addr      = '0;
        exp_data      = '0;
        trig_armed    = 1'b0;
        trig_len      = '0;
        fads_reset    = 1'b1;
        local_errors  = 0;
        timed_out     = 1'b0;
        tests_run     = 0;
        tests_failed  = 0;
        errs_before   = 0;
        seed          = $urandom(32'h5c6f);
        repeat (10) @(posedge adc_clk);
        #1;
        fads_reset = 1'b0;
        fd = $fopen("fads_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file fads_input.txt");
            local_errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(line, fd);
                // blank lines and comments are skipped
                if (code == 0 || line.len() < 3 || line[0] == "#") begin
                    continue;
                end
                op   = line[0];
                rest = line.substr(2, line.len() - 1);
                case (op)
                    "W": begin
                        code = $sscanf(rest, "%h %h", a, d);
                        bus_write(a, d);
                    end
                    "R": begin
                        code = $sscanf(rest, "%h %h", a, d);
                        bus_read(a, d);
                    end
                    "S": begin
                        code = $sscanf(rest, "%d %d", sval, cnt);
                        run_samples(sval, cnt);
                    end
                    "P": begin
                        code = $sscanf(rest, "%d", cnt);
                        wait_trigger(cnt);
                    end
                    "E": begin
                        code = $sscanf(rest, "%s", name);
                        step();
                        total = local_errors + int'(chk_errors);
                        tests_run++;
                        if (total == errs_before) begin
                            $display("test %s: ok", name);
                        end else begin
                            $display("test %s: %0d errors", name, total - errs_before);
                            tests_failed++;
                        end
                        errs_before = total;
                    end
                    default: begin
                        $display("unknown opcode in stimulus line: %s", line);
                        local_errors++;
                    end
                endcase
            end
            $fclose(fd);
        end
        repeat (2) step();
        total = local_errors + int'(chk_errors);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, total);
        if (total == 0 && !timed_out && tests_run > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fads_input.txt
# W offset value (hex) bus write | R offset expected (hex) bus read
# S sample cycles (decimal) stable samples | P trigger cycles | E test name
R 000 FFFFFF06
R 004 FFFFFF10
R 008 000001F4
R 010 1
R 014 4
R 018 40
R 020 1
R 024 7A12
R 028 1E848
R 100 0
R 110 0
R 114 0
R 200 0
E reset_defaults
W 000 3F9C
R 000 FFFFFF9C
W 000 64
R 000 64
W 004 FFFF00C8
R 004 C8
W 008 3E8
R 008 3E8
W 010 3
W 014 5
W 018 A
R 018 A
W 020 0
R 020 0
W 024 14
W 028 25
R 028 25
W 100 55
R 100 0
R 030 0
E threshold_rw
S 150 2
S 0 1
R 200 0
S 150 4
S 180 2
S 0 1
R 20C 11
S 1500 3
S 50 1
R 20C C
S 400 12
S 50 1
R 200 3
R 100 1
R 104 1
R 108 1
R 10C 1
R 110 0
R 114 3
R 204 190
R 208 C
R 20C 22
E classify
S 600 6
S 0 1
R 110 1
R 114 3
R 200 4
R 20C 92
S -1000 60
E positive_no_sort
W 020 1
S 500 5
S 0 1
P 37
R 110 2
R 200 5
R 204 1F4
E sort_trigger
W 020 0
S 300 2
S 300 3
S 300 2
S 0 1
R 208 7
R 204 12C
R 20C 92
R 110 3
R 200 6
E unstable_ignored

//--- sources.f
fads_pkg.sv
fads_us_timer.sv
fads_droplet_detector.sv
fads_droplet_eval.sv
fads_sort_sequencer.sv
fads_regs.sv
fads_top.sv
tb_fads_checker.sv
tb_fads.sv

//--- run.sh
#!/bin/sh
# build and run the droplet sorter testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module tb_fads -o tb_fads_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_fads_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "run passed" \
    || { echo "run failed"; exit 1; }
